// File: design/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// general register file depth.
`define WB_NUM_REGS 32

// ----------------------------------------------------------------------
// csr addresses
// ----------------------------------------------------------------------
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030

// syscall exception code.
`define ECODE_SYS 6'h0b

// field positions inside the csr words.
`define CRMD_PLV       1:0
`define CRMD_IE        2
`define PRMD_PPLV      1:0
`define PRMD_PIE       2
`define ESTAT_ECODE    21:16
`define ESTAT_ESUBCODE 30:22

`endif

// File: design/wb_pkg.sv
package wb_pkg;

  // ----------------------------------------------------------------------
  // datapath widths
  // ----------------------------------------------------------------------

  // data, pc and csr values.
  typedef logic [31:0] word_t;

  // general register number.
  typedef logic [4:0] reg_addr_t;

  // csr address.
  typedef logic [13:0] csr_num_t;

  // ----------------------------------------------------------------------
  // exception and privilege fields
  // ----------------------------------------------------------------------

  // exception code and subcode, as stored in estat.
  typedef logic [5:0] ecode_t;
  typedef logic [8:0] esubcode_t;

  // privilege level, 0 is the most privileged.
  typedef logic [1:0] plv_t;

endpackage

// File: design/wb_stage.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_stage import wb_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  input  logic      ms_valid,
  input  word_t     ms_pc,
  input  logic      ms_gr_we,
  input  reg_addr_t ms_dest,
  input  word_t     ms_result,
  input  logic      ms_csr_re,
  input  logic      ms_csr_we,
  input  csr_num_t  ms_csr_num,
  input  word_t     ms_csr_wmask,
  input  word_t     ms_csr_wvalue,
  input  logic      ms_syscall,
  input  logic      ms_ertn,
  input  word_t     csr_rvalue,

  output logic      ws_valid,
  output word_t     ws_pc,
  output logic      rf_we,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output logic      csr_re,
  output logic      csr_we,
  output csr_num_t  csr_num,
  output word_t     csr_wmask,
  output word_t     csr_wvalue,
  output logic      wb_ex,
  output ecode_t    wb_ecode,
  output esubcode_t wb_esubcode,
  output logic      ertn_flush,
  output logic      flush
);

  logic      gr_we_r;
  reg_addr_t dest_r;
  word_t     result_r;
  logic      csr_re_r;
  logic      csr_we_r;
  logic      syscall_r;
  logic      ertn_r;

  // ----------------------------------------------------------------------
  // writeback register
  // ----------------------------------------------------------------------

  // always ready, a flush kills the younger instruction coming in.
  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid <= 1'b0;
    end else if (flush) begin
      ws_valid <= 1'b0;
    end else begin
      ws_valid <= ms_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ms_valid) begin
      ws_pc      <= ms_pc;
      gr_we_r    <= ms_gr_we;
      dest_r     <= ms_dest;
      result_r   <= ms_result;
      csr_re_r   <= ms_csr_re;
      csr_we_r   <= ms_csr_we;
      csr_num    <= ms_csr_num;
      csr_wmask  <= ms_csr_wmask;
      csr_wvalue <= ms_csr_wvalue;
      syscall_r  <= ms_syscall;
      ertn_r     <= ms_ertn;
    end
  end

  // ----------------------------------------------------------------------
  // commit and exception signalling
  // ----------------------------------------------------------------------
  assign wb_ex      = ws_valid & syscall_r;
  assign ertn_flush = ws_valid & ertn_r;
  assign flush      = wb_ex | ertn_flush;

  // side effects only for a valid, non-flushing instruction.
  assign rf_we  = ws_valid & gr_we_r & ~flush;
  assign csr_re = ws_valid & csr_re_r & ~flush;
  assign csr_we = ws_valid & csr_we_r & ~flush;

  assign rf_waddr = dest_r;
  assign rf_wdata = csr_re ? csr_rvalue : result_r;

  assign wb_ecode    = wb_ex ? `ECODE_SYS : '0;
  assign wb_esubcode = '0;

  a_sys_ertn_excl: assert property (
    @(posedge clk) disable iff (reset) !(ws_valid && syscall_r && ertn_r)
  ) else $error("syscall and ertn in the same writeback instruction");

endmodule

// File: design/csr_file.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module csr_file import wb_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      csr_re,
  input  logic      csr_we,
  input  csr_num_t  csr_num,
  input  word_t     csr_wmask,
  input  word_t     csr_wvalue,
  input  logic      wb_ex,
  input  ecode_t    wb_ecode,
  input  esubcode_t wb_esubcode,
  input  logic      ertn_flush,
  input  word_t     ws_pc,
  output word_t     csr_rvalue,
  output word_t     flush_target
);

  plv_t      crmd_plv;
  logic      crmd_ie;
  plv_t      prmd_pplv;
  logic      prmd_pie;
  ecode_t    estat_ecode;
  esubcode_t estat_esubcode;
  word_t     era;
  word_t     eentry;
  word_t     save0;

  word_t     rd_value;
  word_t     wr_data;

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------

  // unimplemented addresses read zero.
  always_comb begin
    rd_value = '0;
    case (csr_num)
      `CSR_CRMD: begin
        rd_value[`CRMD_PLV] = crmd_plv;
        rd_value[`CRMD_IE]  = crmd_ie;
      end
      `CSR_PRMD: begin
        rd_value[`PRMD_PPLV] = prmd_pplv;
        rd_value[`PRMD_PIE]  = prmd_pie;
      end
      `CSR_ESTAT: begin
        rd_value[`ESTAT_ECODE]    = estat_ecode;
        rd_value[`ESTAT_ESUBCODE] = estat_esubcode;
      end
      `CSR_ERA:    rd_value = era;
      `CSR_EENTRY: rd_value = eentry;
      `CSR_SAVE0:  rd_value = save0;
      default:     rd_value = '0;
    endcase
  end

  assign csr_rvalue = csr_re ? rd_value : '0;

  // old value with the masked bits replaced.
  assign wr_data = (rd_value & ~csr_wmask) | (csr_wvalue & csr_wmask);

  assign flush_target = wb_ex ? eentry : era;

  // ----------------------------------------------------------------------
  // write side and exception update
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
    end else if (wb_ex) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
    end else if (ertn_flush) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else if (csr_we && csr_num == `CSR_CRMD) begin
      crmd_plv <= wr_data[`CRMD_PLV];
      crmd_ie  <= wr_data[`CRMD_IE];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prmd_pplv <= '0;
      prmd_pie  <= 1'b0;
    end else if (wb_ex) begin
      prmd_pplv <= crmd_plv;
      prmd_pie  <= crmd_ie;
    end else if (csr_we && csr_num == `CSR_PRMD) begin
      prmd_pplv <= wr_data[`PRMD_PPLV];
      prmd_pie  <= wr_data[`PRMD_PIE];
    end
  end

  // ecode and esubcode are read-only to software.
  always_ff @(posedge clk) begin
    if (reset) begin
      estat_ecode    <= '0;
      estat_esubcode <= '0;
    end else if (wb_ex) begin
      estat_ecode    <= wb_ecode;
      estat_esubcode <= wb_esubcode;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      era <= '0;
    end else if (wb_ex) begin
      era <= ws_pc;
    end else if (csr_we && csr_num == `CSR_ERA) begin
      era <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      eentry <= '0;
      save0  <= '0;
    end else if (csr_we) begin
      if (csr_num == `CSR_EENTRY) eentry <= wr_data;
      if (csr_num == `CSR_SAVE0)  save0  <= wr_data;
    end
  end

  a_ex_ertn_excl: assert property (
    @(posedge clk) disable iff (reset) !(wb_ex && ertn_flush)
  ) else $error("exception entry and ertn in the same cycle");

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module reg_file import wb_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [`WB_NUM_REGS];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------

  // register zero is never written.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `WB_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // ----------------------------------------------------------------------
  // read ports
  // ----------------------------------------------------------------------

  // no bypass, same-cycle write shows next cycle.
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// File: design/wb_top.sv
`timescale 1ns/1ps

module wb_top import wb_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // memory stage.
  input  logic      ms_valid,
  input  word_t     ms_pc,
  input  word_t     ms_result,
  input  logic      ms_gr_we,
  input  reg_addr_t ms_dest,
  input  logic      ms_csr_re,
  input  logic      ms_csr_we,
  input  csr_num_t  ms_csr_num,
  input  word_t     ms_csr_wmask,
  input  word_t     ms_csr_wvalue,
  input  logic      ms_syscall,
  input  logic      ms_ertn,

  // decode-stage read ports.
  input  reg_addr_t rf_raddr1,
  input  reg_addr_t rf_raddr2,
  output word_t     rf_rdata1,
  output word_t     rf_rdata2,

  output logic      flush,
  output word_t     flush_target
);

  word_t     ws_pc;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      csr_re;
  logic      csr_we;
  csr_num_t  csr_num;
  word_t     csr_wmask;
  word_t     csr_wvalue;
  word_t     csr_rvalue;
  logic      wb_ex;
  ecode_t    wb_ecode;
  esubcode_t wb_esubcode;
  logic      ertn_flush;

  // ----------------------------------------------------------------------
  // writeback stage
  // ----------------------------------------------------------------------
  wb_stage u_wb_stage (
    .clk           (clk),
    .reset         (reset),
    .ms_valid      (ms_valid),
    .ms_pc         (ms_pc),
    .ms_gr_we      (ms_gr_we),
    .ms_dest       (ms_dest),
    .ms_result     (ms_result),
    .ms_csr_re     (ms_csr_re),
    .ms_csr_we     (ms_csr_we),
    .ms_csr_num    (ms_csr_num),
    .ms_csr_wmask  (ms_csr_wmask),
    .ms_csr_wvalue (ms_csr_wvalue),
    .ms_syscall    (ms_syscall),
    .ms_ertn       (ms_ertn),
    .csr_rvalue    (csr_rvalue),
    .ws_valid      (),
    .ws_pc         (ws_pc),
    .rf_we         (rf_we),
    .rf_waddr      (rf_waddr),
    .rf_wdata      (rf_wdata),
    .csr_re        (csr_re),
    .csr_we        (csr_we),
    .csr_num       (csr_num),
    .csr_wmask     (csr_wmask),
    .csr_wvalue    (csr_wvalue),
    .wb_ex         (wb_ex),
    .wb_ecode      (wb_ecode),
    .wb_esubcode   (wb_esubcode),
    .ertn_flush    (ertn_flush),
    .flush         (flush)
  );

  // ----------------------------------------------------------------------
  // csrs and general registers
  // ----------------------------------------------------------------------
  csr_file u_csr_file (
    .clk          (clk),
    .reset        (reset),
    .csr_re       (csr_re),
    .csr_we       (csr_we),
    .csr_num      (csr_num),
    .csr_wmask    (csr_wmask),
    .csr_wvalue   (csr_wvalue),
    .wb_ex        (wb_ex),
    .wb_ecode     (wb_ecode),
    .wb_esubcode  (wb_esubcode),
    .ertn_flush   (ertn_flush),
    .ws_pc        (ws_pc),
    .csr_rvalue   (csr_rvalue),
    .flush_target (flush_target)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

endmodule

// File: tests/wb_tb.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_tb import wb_pkg::*; ();

  typedef struct {
    string     name;
    word_t     pc;
    word_t     result;
    logic      gr_we;
    reg_addr_t dest;
    logic      csr_re;
    logic      csr_we;
    csr_num_t  csr_num;
    word_t     wmask;
    word_t     wvalue;
    logic      syscall;
    logic      ertn;
    logic      kill_next;
    logic      exp_flush;
    word_t     exp_target;
    reg_addr_t chk_reg;
    word_t     exp_val;
    reg_addr_t chk_reg2;
    word_t     exp_val2;
  } row_t;

  logic      clk;
  logic      reset;
  logic      ms_valid;
  word_t     ms_pc;
  word_t     ms_result;
  logic      ms_gr_we;
  reg_addr_t ms_dest;
  logic      ms_csr_re;
  logic      ms_csr_we;
  csr_num_t  ms_csr_num;
  word_t     ms_csr_wmask;
  word_t     ms_csr_wvalue;
  logic      ms_syscall;
  logic      ms_ertn;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      flush;
  word_t     flush_target;

  row_t        rows[$];
  logic [31:0] lfsr_state = 32'he39c_5d85;
  word_t       next_pc = 32'h1c00_0000;
  logic        table_ready = 1'b0;

  // reference model of the architectural state.
  word_t  model_regs [`WB_NUM_REGS];
  plv_t   m_plv;
  logic   m_ie;
  plv_t   m_pplv;
  logic   m_pie;
  ecode_t m_ecode;
  word_t  m_era;
  word_t  m_eentry;
  word_t  m_save0;

  wb_top dut (
    .clk           (clk),
    .reset         (reset),
    .ms_valid      (ms_valid),
    .ms_pc         (ms_pc),
    .ms_result     (ms_result),
    .ms_gr_we      (ms_gr_we),
    .ms_dest       (ms_dest),
    .ms_csr_re     (ms_csr_re),
    .ms_csr_we     (ms_csr_we),
    .ms_csr_num    (ms_csr_num),
    .ms_csr_wmask  (ms_csr_wmask),
    .ms_csr_wvalue (ms_csr_wvalue),
    .ms_syscall    (ms_syscall),
    .ms_ertn       (ms_ertn),
    .rf_raddr1     (rf_raddr1),
    .rf_raddr2     (rf_raddr2),
    .rf_rdata1     (rf_rdata1),
    .rf_rdata2     (rf_rdata2),
    .flush         (flush),
    .flush_target  (flush_target)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // random source and model
  // ----------------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic word_t csr_model_read(csr_num_t num);
    word_t v;
    v = '0;
    case (num)
      `CSR_CRMD: begin
        v[`CRMD_PLV] = m_plv;
        v[`CRMD_IE]  = m_ie;
      end
      `CSR_PRMD: begin
        v[`PRMD_PPLV] = m_pplv;
        v[`PRMD_PIE]  = m_pie;
      end
      `CSR_ESTAT:  v[`ESTAT_ECODE] = m_ecode;
      `CSR_ERA:    v = m_era;
      `CSR_EENTRY: v = m_eentry;
      `CSR_SAVE0:  v = m_save0;
      default:     v = '0;
    endcase
    return v;
  endfunction

  task automatic csr_model_write(csr_num_t num, word_t mask, word_t value);
    word_t nv;
    nv = (csr_model_read(num) & ~mask) | (value & mask);
    case (num)
      `CSR_CRMD: begin
        m_plv = nv[`CRMD_PLV];
        m_ie  = nv[`CRMD_IE];
      end
      `CSR_PRMD: begin
        m_pplv = nv[`PRMD_PPLV];
        m_pie  = nv[`PRMD_PIE];
      end
      `CSR_ERA:    m_era = nv;
      `CSR_EENTRY: m_eentry = nv;
      `CSR_SAVE0:  m_save0 = nv;
      default:     ;
    endcase
  endtask

  // ----------------------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------------------
  function automatic row_t new_row(string name);
    row_t r;
    r.name       = name;
    r.pc         = next_pc;
    r.result     = '0;
    r.gr_we      = 1'b0;
    r.dest       = '0;
    r.csr_re     = 1'b0;
    r.csr_we     = 1'b0;
    r.csr_num    = '0;
    r.wmask      = '0;
    r.wvalue     = '0;
    r.syscall    = 1'b0;
    r.ertn       = 1'b0;
    r.kill_next  = 1'b0;
    r.exp_flush  = 1'b0;
    r.exp_target = '0;
    r.chk_reg    = '0;
    r.exp_val    = '0;
    r.chk_reg2   = '0;
    r.exp_val2   = '0;
    next_pc = next_pc + 4;
    return r;
  endfunction

  task automatic push_row(row_t r);
    word_t wdata;
    if (rows.size() > 0 && rows[$].kill_next) begin
      // younger instruction behind a flush, never commits.
      r.exp_flush = 1'b0;
    end else if (r.syscall) begin
      r.exp_flush  = 1'b1;
      r.exp_target = m_eentry;
      m_pplv  = m_plv;
      m_pie   = m_ie;
      m_plv   = '0;
      m_ie    = 1'b0;
      m_era   = r.pc;
      m_ecode = `ECODE_SYS;
    end else if (r.ertn) begin
      r.exp_flush  = 1'b1;
      r.exp_target = m_era;
      m_plv = m_pplv;
      m_ie  = m_pie;
    end else begin
      wdata = r.csr_re ? csr_model_read(r.csr_num) : r.result;
      if (r.csr_we) begin
        csr_model_write(r.csr_num, r.wmask, r.wvalue);
      end
      if (r.gr_we && r.dest != '0) begin
        model_regs[r.dest] = wdata;
      end
    end
    r.exp_val = model_regs[r.chk_reg];
    // second read port looks at the mirrored register number.
    r.chk_reg2 = ~r.chk_reg;
    r.exp_val2 = model_regs[r.chk_reg2];
    rows.push_back(r);
  endtask

  task automatic add_gr(string name, reg_addr_t dest, logic we);
    row_t r;
    r = new_row(name);
    r.gr_we   = we;
    r.dest    = dest;
    r.result  = rand_word();
    r.chk_reg = dest;
    push_row(r);
  endtask

  task automatic add_csr_wr(string name, csr_num_t num, word_t mask, word_t value);
    row_t r;
    r = new_row(name);
    r.csr_we  = 1'b1;
    r.csr_num = num;
    r.wmask   = mask;
    r.wvalue  = value;
    push_row(r);
  endtask

  task automatic add_csr_rd(string name, csr_num_t num, reg_addr_t dest);
    row_t r;
    r = new_row(name);
    r.csr_re  = 1'b1;
    r.csr_num = num;
    r.gr_we   = 1'b1;
    r.dest    = dest;
    r.chk_reg = dest;
    push_row(r);
  endtask

  // syscall carries a register write that must be dropped.
  task automatic add_sys(string name, reg_addr_t dest, logic kill_next);
    row_t r;
    r = new_row(name);
    r.syscall   = 1'b1;
    r.gr_we     = 1'b1;
    r.dest      = dest;
    r.result    = rand_word();
    r.chk_reg   = dest;
    r.kill_next = kill_next;
    push_row(r);
  endtask

  task automatic add_ertn(string name);
    row_t r;
    r = new_row(name);
    r.ertn = 1'b1;
    push_row(r);
  endtask

  task automatic build_table();
    for (int k = 0; k < `WB_NUM_REGS; k++) begin
      model_regs[k] = '0;
    end
    m_plv    = '0;
    m_ie     = 1'b0;
    m_pplv   = '0;
    m_pie    = 1'b0;
    m_ecode  = '0;
    m_era    = '0;
    m_eentry = '0;
    m_save0  = '0;
    add_gr("gr_write_r1", 5'd1, 1'b1);
    add_gr("gr_write_r5", 5'd5, 1'b1);
    add_gr("gr_write_r12", 5'd12, 1'b1);
    add_gr("gr_write_r31", 5'd31, 1'b1);
    add_gr("gr_write_r0", 5'd0, 1'b1);
    add_gr("gr_we_low", 5'd5, 1'b0);
    add_csr_wr("save0_init", `CSR_SAVE0, 32'hffff_ffff, rand_word());
    add_csr_wr("save0_mask", `CSR_SAVE0, 32'h00ff_f00f, rand_word());
    add_csr_rd("save0_read", `CSR_SAVE0, 5'd7);
    add_csr_wr("eentry_set", `CSR_EENTRY, 32'hffff_ffff, 32'h1c00_8000);
    add_sys("syscall", 5'd5, 1'b0);
    add_csr_rd("era_read", `CSR_ERA, 5'd10);
    add_csr_rd("estat_read", `CSR_ESTAT, 5'd11);
    add_csr_wr("crmd_set", `CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
    add_sys("syscall_plv3", 5'd0, 1'b0);
    add_csr_rd("crmd_after_sys", `CSR_CRMD, 5'd13);
    add_csr_rd("prmd_after_sys", `CSR_PRMD, 5'd14);
    add_ertn("ertn");
    add_csr_rd("crmd_restored", `CSR_CRMD, 5'd15);
    add_sys("syscall_kill", 5'd1, 1'b1);
    add_gr("killed_write", 5'd12, 1'b1);
    add_gr("after_kill", 5'd12, 1'b1);
  endtask

  // ----------------------------------------------------------------------
  // drive and check
  // ----------------------------------------------------------------------
  task automatic drive_row(row_t r);
    ms_valid      <= 1'b1;
    ms_pc         <= r.pc;
    ms_result     <= r.result;
    ms_gr_we      <= r.gr_we;
    ms_dest       <= r.dest;
    ms_csr_re     <= r.csr_re;
    ms_csr_we     <= r.csr_we;
    ms_csr_num    <= r.csr_num;
    ms_csr_wmask  <= r.wmask;
    ms_csr_wvalue <= r.wvalue;
    ms_syscall    <= r.syscall;
    ms_ertn       <= r.ertn;
  endtask

  task automatic drive_idle();
    ms_valid   <= 1'b0;
    ms_gr_we   <= 1'b0;
    ms_csr_re  <= 1'b0;
    ms_csr_we  <= 1'b0;
    ms_syscall <= 1'b0;
    ms_ertn    <= 1'b0;
  endtask

  task automatic check_value(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flush(row_t r);
    check_value({r.name, " flush"}, {31'b0, r.exp_flush}, {31'b0, flush});
    if (r.exp_flush) begin
      check_value({r.name, " target"}, r.exp_target, flush_target);
    end
  endtask

  task automatic check_regs(row_t r);
    check_value(r.name, r.exp_val, rf_rdata1);
    check_value({r.name, " port2"}, r.exp_val2, rf_rdata2);
  endtask

  initial begin
    reset         = 1'b1;
    ms_valid      = 1'b0;
    ms_pc         = '0;
    ms_result     = '0;
    ms_gr_we      = 1'b0;
    ms_dest       = '0;
    ms_csr_re     = 1'b0;
    ms_csr_we     = 1'b0;
    ms_csr_num    = '0;
    ms_csr_wmask  = '0;
    ms_csr_wvalue = '0;
    ms_syscall    = 1'b0;
    ms_ertn       = 1'b0;
    rf_raddr1     = '0;
    rf_raddr2     = '0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      drive_row(rows[i]);
      @(posedge clk);
      // back to back on a kill row, otherwise an idle cycle.
      if (rows[i].kill_next) begin
        drive_row(rows[i + 1]);
      end else begin
        drive_idle();
      end
      @(negedge clk);
      check_flush(rows[i]);
      @(posedge clk);
      drive_idle();
      rf_raddr1 <= rows[i].chk_reg;
      rf_raddr2 <= rows[i].chk_reg2;
      @(negedge clk);
      check_regs(rows[i]);
      if (rows[i].kill_next) begin
        i++;
        check_flush(rows[i]);
        @(posedge clk);
        rf_raddr1 <= rows[i].chk_reg;
        rf_raddr2 <= rows[i].chk_reg2;
        @(negedge clk);
        check_regs(rows[i]);
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 3 + 20) @(posedge clk);
    $display("timeout: the stimulus table did not finish in time");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: project.f
+incdir+design
design/wb_pkg.sv
design/wb_stage.sv
design/csr_file.sv
design/reg_file.sv
design/wb_top.sv
tests/wb_tb.sv

// File: Bender.yml
package:
  name: wb_tail

sources:
  - include_dirs:
      - design
    files:
      - design/wb_pkg.sv
      - design/wb_stage.sv
      - design/csr_file.sv
      - design/reg_file.sv
      - design/wb_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/wb_tb.sv
